//--- list.f
+incdir+source
source/timestamp_pkg.sv
source/axi_lite_slave.sv
source/timestamp_regs.sv
source/stamp_counter.sv
source/timestamp_top.sv
test/timestamp_checker.sv
test/tb_timestamp.sv

//--- run.sh
#!/bin/sh
# Build and run the timestamp unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_timestamp -f list.f
./obj_dir/Vtb_timestamp > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

//--- source/axi_lite_slave.sv
// ------------------------------
// AXI-Lite slave
// Accepts one read or write at a
// time, pulses a register strobe
// and holds the response until
// the master takes it
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module axi_lite_slave (
  input  wire logic                          axi_aclk,
  input  wire logic                          reset,

  // Write address and data
  input  wire logic [`TS_ADDR_WIDTH-1:0]     s_axi_awaddr,
  input  wire logic                          s_axi_awvalid,
  output logic                               s_axi_awready,
  input  wire logic [`TS_DATA_WIDTH-1:0]     s_axi_wdata,
  input  wire logic [`TS_DATA_WIDTH/8-1:0]   s_axi_wstrb,
  input  wire logic                          s_axi_wvalid,
  output logic                               s_axi_wready,

  // Write response
  output logic [1:0]                         s_axi_bresp,
  output logic                               s_axi_bvalid,
  input  wire logic                          s_axi_bready,

  // Read address
  input  wire logic [`TS_ADDR_WIDTH-1:0]     s_axi_araddr,
  input  wire logic                          s_axi_arvalid,
  output logic                               s_axi_arready,

  // Read data
  output logic [`TS_DATA_WIDTH-1:0]          s_axi_rdata,
  output logic [1:0]                         s_axi_rresp,
  output logic                               s_axi_rvalid,
  input  wire logic                          s_axi_rready,

  // Register bank side
  output timestamp_pkg::bus_req_t            req,
  input  wire timestamp_pkg::bus_rsp_t       rsp
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic pending;
  logic wr_go;
  logic rd_go;

  // No new address while a response waits
  assign pending = s_axi_bvalid | s_axi_rvalid;

  // Write wins when both arrive together
  assign wr_go = s_axi_awvalid & s_axi_wvalid & ~pending;
  assign rd_go = s_axi_arvalid & ~pending & ~wr_go;

  assign s_axi_awready = wr_go;
  assign s_axi_wready  = wr_go;
  assign s_axi_arready = rd_go;

  // Strobes last exactly the handshake cycle
  always_comb begin
    req.wr    = wr_go;
    req.rd    = rd_go;
    req.addr  = wr_go ? s_axi_awaddr : s_axi_araddr;
    req.wdata = s_axi_wdata;
    req.wstrb = s_axi_wstrb;
  end

  // Write response channel
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      s_axi_bvalid <= 1'b0;
    end else if (wr_go) begin
      s_axi_bvalid <= 1'b1;
    end else if (s_axi_bready) begin
      s_axi_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (wr_go) begin
      s_axi_bresp <= rsp.error ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Read data channel
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      s_axi_rvalid <= 1'b0;
    end else if (rd_go) begin
      s_axi_rvalid <= 1'b1;
    end else if (s_axi_rready) begin
      s_axi_rvalid <= 1'b0;
    end
  end

  // Data captured in the rd cycle, held while rvalid waits
  always_ff @(posedge axi_aclk) begin
    if (rd_go) begin
      s_axi_rdata <= rsp.rdata;
      s_axi_rresp <= rsp.error ? RESP_SLVERR : RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- source/stamp_counter.sv
// ------------------------------
// Stamp counter
// 64-bit 32.32 time that adds a
// fixed fraction every cycle,
// with preset load and freeze
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module stamp_counter (
  input  wire logic                     axi_aclk,
  input  wire logic                     reset,
  input  wire timestamp_pkg::ts_ctrl_t  ctrl,
  input  wire timestamp_pkg::stamp_t    preset,
  output timestamp_pkg::stamp_t         stamp
);

  localparam logic [`TS_STAMP_WIDTH-1:0] INCREMENT = `TS_INCREMENT;

  logic load_q;
  logic load_edge;

  // Previous load bit for edge detection
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      load_q <= 1'b0;
    end else begin
      load_q <= ctrl.load;
    end
  end

  assign load_edge = ctrl.load & ~load_q;

  // Load beats freeze, freeze beats counting
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      stamp.value <= '0;
    end else if (load_edge) begin
      stamp <= preset;
    end else if (!ctrl.freeze) begin
      stamp.value <= stamp.value + INCREMENT;
    end
  end

endmodule

`default_nettype wire

//--- source/timestamp_pkg.sv
// ------------------------------
// Timestamp unit types
// Register bus request/response,
// control bits and the stamp word
// ------------------------------

`default_nettype none

package timestamp_pkg;

  `include "timestamp_settings.svh"

  // One-cycle register access from the AXI slave
  typedef struct packed {
    logic                          wr;
    logic                          rd;
    logic [`TS_ADDR_WIDTH-1:0]     addr;
    logic [`TS_DATA_WIDTH-1:0]     wdata;
    logic [`TS_DATA_WIDTH/8-1:0]   wstrb;
  } bus_req_t;

  // Combinational answer for the current address
  typedef struct packed {
    logic [`TS_DATA_WIDTH-1:0] rdata;
    logic                      error;
  } bus_rsp_t;

  // Two low bits of the control register
  typedef struct packed {
    logic freeze;
    logic load;
  } ts_ctrl_t;

  // Seconds in the high word, fraction in the low word
  typedef struct packed {
    logic [`TS_DATA_WIDTH-1:0] hi;
    logic [`TS_DATA_WIDTH-1:0] lo;
  } stamp_words_t;

  // Counter sees one number, the bus sees two words
  typedef union packed {
    logic [`TS_STAMP_WIDTH-1:0] value;
    stamp_words_t               words;
  } stamp_t;

endpackage

`default_nettype wire

//--- source/timestamp_regs.sv
// ------------------------------
// Timestamp register bank
// Control and preset registers,
// count readback with a coherent
// high-word snapshot
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module timestamp_regs (
  input  wire logic                     axi_aclk,
  input  wire logic                     reset,
  input  wire timestamp_pkg::bus_req_t  req,
  output timestamp_pkg::bus_rsp_t       rsp,
  input  wire timestamp_pkg::stamp_t    stamp,
  output timestamp_pkg::ts_ctrl_t       ctrl,
  output timestamp_pkg::stamp_t         preset
);

  import timestamp_pkg::*;

  logic [`TS_DATA_WIDTH-1:0] count_hi_q;

  // Byte-lane merge of a write into an existing word
  function automatic logic [`TS_DATA_WIDTH-1:0] merge_bytes(
    input logic [`TS_DATA_WIDTH-1:0]   old_word,
    input logic [`TS_DATA_WIDTH-1:0]   new_word,
    input logic [`TS_DATA_WIDTH/8-1:0] strb
  );
    logic [`TS_DATA_WIDTH-1:0] result;
    result = old_word;
    for (int i = 0; i < `TS_DATA_WIDTH/8; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // Writable registers
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      ctrl         <= '0;
      preset.value <= '0;
    end else if (req.wr) begin
      case (req.addr)
        `TS_REG_CTRL: begin
          // Only the two low bits exist
          if (req.wstrb[0]) begin
            ctrl <= ts_ctrl_t'(req.wdata[1:0]);
          end
        end
        `TS_REG_PRESET_LO: begin
          preset.words.lo <= merge_bytes(preset.words.lo, req.wdata, req.wstrb);
        end
        `TS_REG_PRESET_HI: begin
          preset.words.hi <= merge_bytes(preset.words.hi, req.wdata, req.wstrb);
        end
        default: begin
        end
      endcase
    end
  end

  // High word frozen when the low word is read
  always_ff @(posedge axi_aclk) begin
    if (reset) begin
      count_hi_q <= '0;
    end else if (req.rd && req.addr == `TS_REG_COUNT_LO) begin
      count_hi_q <= stamp.words.hi;
    end
  end

  // Answer for the address on the bus this cycle
  always_comb begin
    rsp.rdata = '0;
    rsp.error = 1'b0;
    if (req.wr) begin
      case (req.addr)
        `TS_REG_CTRL, `TS_REG_PRESET_LO, `TS_REG_PRESET_HI: rsp.error = 1'b0;
        default: rsp.error = 1'b1;
      endcase
    end else begin
      case (req.addr)
        `TS_REG_CTRL:      rsp.rdata = `TS_DATA_WIDTH'(ctrl);
        `TS_REG_PRESET_LO: rsp.rdata = preset.words.lo;
        `TS_REG_PRESET_HI: rsp.rdata = preset.words.hi;
        `TS_REG_COUNT_LO:  rsp.rdata = stamp.words.lo;
        `TS_REG_COUNT_HI:  rsp.rdata = count_hi_q;
        default:           rsp.error = 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/timestamp_settings.svh
// ------------------------------
// Timestamp unit settings
// Bus widths, register map and
// the per-cycle stamp increment
// ------------------------------

`ifndef TIMESTAMP_SETTINGS_SVH
`define TIMESTAMP_SETTINGS_SVH

// Bus and stamp widths
`define TS_DATA_WIDTH  32
`define TS_ADDR_WIDTH  8
`define TS_STAMP_WIDTH 64

// Fraction units per cycle, about 2^32 / 250 MHz
`define TS_INCREMENT 17

// Register offsets
`define TS_REG_CTRL      8'h00
`define TS_REG_PRESET_LO 8'h04
`define TS_REG_PRESET_HI 8'h08
`define TS_REG_COUNT_LO  8'h0C
`define TS_REG_COUNT_HI  8'h10

`endif

//--- source/timestamp_top.sv
// ------------------------------
// Timestamp unit top level
// AXI-Lite slave, register bank
// and stamp counter
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module timestamp_top (
  input  wire logic                          axi_aclk,
  input  wire logic                          reset,

  // AXI-Lite slave port
  input  wire logic [`TS_ADDR_WIDTH-1:0]     s_axi_awaddr,
  input  wire logic                          s_axi_awvalid,
  output logic                               s_axi_awready,
  input  wire logic [`TS_DATA_WIDTH-1:0]     s_axi_wdata,
  input  wire logic [`TS_DATA_WIDTH/8-1:0]   s_axi_wstrb,
  input  wire logic                          s_axi_wvalid,
  output logic                               s_axi_wready,
  output logic [1:0]                         s_axi_bresp,
  output logic                               s_axi_bvalid,
  input  wire logic                          s_axi_bready,
  input  wire logic [`TS_ADDR_WIDTH-1:0]     s_axi_araddr,
  input  wire logic                          s_axi_arvalid,
  output logic                               s_axi_arready,
  output logic [`TS_DATA_WIDTH-1:0]          s_axi_rdata,
  output logic [1:0]                         s_axi_rresp,
  output logic                               s_axi_rvalid,
  input  wire logic                          s_axi_rready,

  // Running time
  output timestamp_pkg::stamp_t              stamp_counter
);

  import timestamp_pkg::*;

  bus_req_t req;
  bus_rsp_t rsp;
  ts_ctrl_t ctrl;
  stamp_t   preset;

  axi_lite_slave u_axi_lite_slave (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .req           (req),
    .rsp           (rsp)
  );

  timestamp_regs u_timestamp_regs (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .req      (req),
    .rsp      (rsp),
    .stamp    (stamp_counter),
    .ctrl     (ctrl),
    .preset   (preset)
  );

  // Counter output goes straight to the top port
  stamp_counter u_stamp_counter (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .ctrl     (ctrl),
    .preset   (preset),
    .stamp    (stamp_counter)
  );

endmodule

`default_nettype wire

//--- test/tb_timestamp.sv
// ------------------------------
// Timestamp unit testbench
// Clock, reset, AXI-Lite master
// tasks and the stimulus table
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module tb_timestamp;

  import timestamp_pkg::*;

  localparam logic [1:0] OKAY           = 2'b00;
  localparam logic [1:0] SLVERR         = 2'b10;
  localparam logic [1:0] MODE_EXACT     = 2'd0;
  localparam logic [1:0] MODE_LIVE_LO   = 2'd1;
  localparam logic [1:0] MODE_SNAP_HI   = 2'd2;
  localparam logic [1:0] MODE_RESP_ONLY = 2'd3;

  // One access and the response it must get
  typedef struct packed {
    logic                        write;
    logic [`TS_ADDR_WIDTH-1:0]   addr;
    logic [`TS_DATA_WIDTH-1:0]   data;
    logic [`TS_DATA_WIDTH/8-1:0] strb;
    logic [`TS_DATA_WIDTH-1:0]   exp_data;
    logic [1:0]                  exp_resp;
    logic [1:0]                  mode;
  } step_t;

  logic                        axi_aclk;
  logic                        reset;
  logic [`TS_ADDR_WIDTH-1:0]   s_axi_awaddr, s_axi_araddr;
  logic                        s_axi_awvalid, s_axi_awready;
  logic [`TS_DATA_WIDTH-1:0]   s_axi_wdata, s_axi_rdata;
  logic [`TS_DATA_WIDTH/8-1:0] s_axi_wstrb;
  logic                        s_axi_wvalid, s_axi_wready;
  logic                        s_axi_bvalid, s_axi_bready;
  logic                        s_axi_arvalid, s_axi_arready;
  logic                        s_axi_rvalid, s_axi_rready;
  logic [1:0]                  s_axi_bresp, s_axi_rresp;
  stamp_t                      stamp_counter;
  logic [`TS_DATA_WIDTH-1:0]   exp_data;
  logic [1:0]                  exp_resp, exp_mode;
  int                          error_count;
  int                          resp_count;
  int                          tb_errors = 0;
  logic                        table_ready = 1'b0;
  step_t                       steps[$];

  timestamp_top u_timestamp_top (.*);

  timestamp_checker u_checker (.*);

  always #2 axi_aclk = ~axi_aclk;

  function automatic void add_step(input logic write, input logic [7:0] addr,
                                   input logic [31:0] data, input logic [3:0] strb,
                                   input logic [31:0] exp_d, input logic [1:0] resp,
                                   input logic [1:0] mode);
    step_t s;
    s = '{write, addr, data, strb, exp_d, resp, mode};
    steps.push_back(s);
  endfunction

  task automatic build_table();
    logic [31:0] p_lo;
    logic [31:0] p_hi;
    logic [31:0] p_hi_new;
    logic [31:0] hi_merged;
    // Low fraction within one increment of wrapping, so the first count carries
    p_lo      = 32'hFFFF_FFF0 | ($urandom & 32'h0000_000F);
    p_hi      = $urandom;
    p_hi_new  = $urandom;
    hi_merged = {p_hi[31:24], p_hi_new[23:16], p_hi[15:8], p_hi_new[7:0]};
    add_step(1'b0, `TS_REG_CTRL, 32'h0, 4'h0, 32'h0, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_PRESET_LO, 32'h0, 4'h0, 32'h0, OKAY, MODE_EXACT);
    add_step(1'b1, `TS_REG_PRESET_LO, p_lo, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b1, `TS_REG_PRESET_HI, p_hi, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b1, `TS_REG_PRESET_HI, p_hi_new, 4'b0101, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b0, `TS_REG_PRESET_LO, 32'h0, 4'h0, p_lo, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_PRESET_HI, 32'h0, 4'h0, hi_merged, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_COUNT_LO, 32'h0, 4'h0, 32'h0, OKAY, MODE_LIVE_LO);
    add_step(1'b0, `TS_REG_COUNT_HI, 32'h0, 4'h0, 32'h0, OKAY, MODE_SNAP_HI);
    // Load, freeze, load while frozen, then resume
    add_step(1'b1, `TS_REG_CTRL, 32'h1, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b0, `TS_REG_CTRL, 32'h0, 4'h0, 32'h1, OKAY, MODE_EXACT);
    add_step(1'b1, `TS_REG_CTRL, 32'h2, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b1, `TS_REG_CTRL, 32'h3, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b0, `TS_REG_COUNT_LO, 32'h0, 4'h0, p_lo, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_COUNT_HI, 32'h0, 4'h0, hi_merged, OKAY, MODE_EXACT);
    // Snapshot taken while frozen must survive the carry after resuming
    add_step(1'b0, `TS_REG_COUNT_LO, 32'h0, 4'h0, p_lo, OKAY, MODE_EXACT);
    add_step(1'b1, `TS_REG_CTRL, 32'h0, 4'hF, 32'h0, OKAY, MODE_RESP_ONLY);
    add_step(1'b0, `TS_REG_COUNT_HI, 32'h0, 4'h0, hi_merged, OKAY, MODE_EXACT);
    // Error accesses
    add_step(1'b1, `TS_REG_COUNT_LO, $urandom, 4'hF, 32'h0, SLVERR, MODE_RESP_ONLY);
    add_step(1'b1, 8'h20, $urandom, 4'hF, 32'h0, SLVERR, MODE_RESP_ONLY);
    add_step(1'b0, 8'h24, 32'h0, 4'h0, 32'h0, SLVERR, MODE_RESP_ONLY);
    add_step(1'b0, `TS_REG_CTRL, 32'h0, 4'h0, 32'h0, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_PRESET_HI, 32'h0, 4'h0, hi_merged, OKAY, MODE_EXACT);
    add_step(1'b0, `TS_REG_COUNT_LO, 32'h0, 4'h0, 32'h0, OKAY, MODE_LIVE_LO);
    add_step(1'b0, `TS_REG_COUNT_HI, 32'h0, 4'h0, 32'h0, OKAY, MODE_SNAP_HI);
  endtask

  // Called 1 ns after a rising edge, returns at the same point
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int hold;
    hold          = $urandom_range(3, 0);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do @(negedge axi_aclk); while (!s_axi_awready);
    @(posedge axi_aclk);
    #1;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    repeat (hold) begin
      @(posedge axi_aclk);
      #1;
    end
    s_axi_bready = 1'b1;
    do @(negedge axi_aclk); while (!s_axi_bvalid);
    @(posedge axi_aclk);
    #1;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr);
    int hold;
    hold          = $urandom_range(3, 0);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(negedge axi_aclk); while (!s_axi_arready);
    @(posedge axi_aclk);
    #1;
    s_axi_arvalid = 1'b0;
    repeat (hold) begin
      @(posedge axi_aclk);
      #1;
    end
    s_axi_rready = 1'b1;
    do @(negedge axi_aclk); while (!s_axi_rvalid);
    @(posedge axi_aclk);
    #1;
    s_axi_rready = 1'b0;
  endtask

  initial begin
    int seed_ret;
    axi_aclk      = 1'b0;
    reset         = 1'b1;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    exp_data      = '0;
    exp_resp      = OKAY;
    exp_mode      = MODE_EXACT;
    seed_ret      = $urandom(32'hc294_b758);
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge axi_aclk);
    #1;
    reset = 1'b0;
    // A few free-running cycles before the first access
    repeat (4) @(posedge axi_aclk);
    #1;
    foreach (steps[i]) begin
      exp_data = steps[i].exp_data;
      exp_resp = steps[i].exp_resp;
      exp_mode = steps[i].mode;
      if (steps[i].write) begin
        axi_write(steps[i].addr, steps[i].data, steps[i].strb);
      end else begin
        axi_read(steps[i].addr);
      end
    end
    repeat (20) @(posedge axi_aclk);
    if (resp_count != steps.size()) begin
      $display("Checker saw %0d responses but %0d accesses were made", resp_count, steps.size());
      tb_errors = tb_errors + 1;
    end
    $display("Errors: %0d from checker, %0d from testbench", error_count, tb_errors);
    if (error_count + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int limit;
    wait (table_ready);
    limit = steps.size() * 40 + 100;
    repeat (limit) @(posedge axi_aclk);
    $display("Timeout: the test did not finish within %0d cycles", limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/timestamp_checker.sv
// ------------------------------
// Timestamp unit checker
// Models the stamp from observed
// AXI writes, compares the stamp
// port and every bus response
// ------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "timestamp_settings.svh"

module timestamp_checker (
  input  wire logic                        axi_aclk,
  input  wire logic                        reset,
  input  wire logic                        s_axi_awvalid, s_axi_awready, s_axi_wready,
  input  wire logic                        s_axi_arvalid, s_axi_arready,
  input  wire logic                        s_axi_bvalid, s_axi_bready,
  input  wire logic                        s_axi_rvalid, s_axi_rready,
  input  wire logic [`TS_ADDR_WIDTH-1:0]   s_axi_awaddr, s_axi_araddr,
  input  wire logic [`TS_DATA_WIDTH-1:0]   s_axi_wdata, s_axi_rdata, exp_data,
  input  wire logic [`TS_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  wire logic [1:0]                  s_axi_bresp, s_axi_rresp, exp_resp, exp_mode,
  input  wire timestamp_pkg::stamp_t       stamp_counter,
  output int                               error_count,
  output int                               resp_count
);

  import timestamp_pkg::*;

  // Where the expected read data comes from
  localparam logic [1:0] MODE_LIVE_LO   = 2'd1;
  localparam logic [1:0] MODE_SNAP_HI   = 2'd2;
  localparam logic [1:0] MODE_RESP_ONLY = 2'd3;

  stamp_t                    model;
  stamp_t                    preset;
  ts_ctrl_t                  ctrl;
  logic                      load_prev;
  logic [`TS_DATA_WIDTH-1:0] snap_hi;
  logic [`TS_DATA_WIDTH-1:0] want_rdata;
  logic [1:0]                want_bresp;
  logic [1:0]                want_rresp;
  logic                      want_data;
  int                        port_errors = 0;
  int                        rsp_errors = 0;
  int                        rsp_total = 0;

  assign error_count = port_errors + rsp_errors;
  assign resp_count  = rsp_total;

  function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Registers take a write one cycle after its handshake,
  // a rising load reaches the stamp one cycle after that
  always @(posedge axi_aclk) begin
    if (reset) begin
      model.value  <= '0;
      preset.value <= '0;
      ctrl         <= '0;
      load_prev    <= 1'b0;
    end else begin
      load_prev <= ctrl.load;
      if (ctrl.load && !load_prev) begin
        model <= preset;
      end else if (!ctrl.freeze) begin
        model.value <= model.value + `TS_STAMP_WIDTH'(`TS_INCREMENT);
      end
      if (s_axi_awvalid && s_axi_awready) begin
        case (s_axi_awaddr)
          `TS_REG_CTRL:      ctrl <= s_axi_wstrb[0] ? ts_ctrl_t'(s_axi_wdata[1:0]) : ctrl;
          `TS_REG_PRESET_LO: preset.words.lo <= apply_strobe(preset.words.lo, s_axi_wdata,
                                                             s_axi_wstrb);
          `TS_REG_PRESET_HI: preset.words.hi <= apply_strobe(preset.words.hi, s_axi_wdata,
                                                             s_axi_wstrb);
          default: begin
          end
        endcase
      end
    end
  end

  // Expected answers are fixed at the address handshake
  always @(posedge axi_aclk) begin
    if (!reset) begin
      if (s_axi_awvalid && s_axi_awready) begin
        want_bresp <= exp_resp;
      end
      if (s_axi_arvalid && s_axi_arready) begin
        want_rresp <= exp_resp;
        want_data  <= exp_mode != MODE_RESP_ONLY;
        case (exp_mode)
          MODE_LIVE_LO: want_rdata <= model.words.lo;
          MODE_SNAP_HI: want_rdata <= snap_hi;
          default:      want_rdata <= exp_data;
        endcase
        // High word as it stood when the low word was read
        if (s_axi_araddr == `TS_REG_COUNT_LO) begin
          snap_hi <= model.words.hi;
        end
      end
      if (s_axi_bvalid && s_axi_bready) begin
        rsp_total = rsp_total + 1;
        if (s_axi_bresp !== want_bresp) begin
          $display("ERROR s_axi_bresp expected %h actual %h", want_bresp, s_axi_bresp);
          rsp_errors = rsp_errors + 1;
        end
      end
      if (s_axi_rvalid && s_axi_rready) begin
        rsp_total = rsp_total + 1;
        if (s_axi_rresp !== want_rresp) begin
          $display("ERROR s_axi_rresp expected %h actual %h", want_rresp, s_axi_rresp);
          rsp_errors = rsp_errors + 1;
        end
        if (want_data && s_axi_rdata !== want_rdata) begin
          $display("ERROR s_axi_rdata expected %h actual %h", want_rdata, s_axi_rdata);
          rsp_errors = rsp_errors + 1;
        end
      end
    end
  end

  // Mid-cycle, where ports and model are all settled
  always @(negedge axi_aclk) begin
    if (!reset && stamp_counter.value !== model.value) begin
      $display("ERROR stamp_counter expected %h actual %h", model.value, stamp_counter.value);
      port_errors = port_errors + 1;
    end
    // Address and data of a write are taken in the same cycle
    if (!reset && s_axi_wready !== s_axi_awready) begin
      $display("ERROR s_axi_wready expected %h actual %h", s_axi_awready, s_axi_wready);
      port_errors = port_errors + 1;
    end
  end

endmodule

`default_nettype wire
